/* irq_path.f */
+incdir+source
source/irq_map_pkg.sv
source/mtimer_pkg.sv
source/irq_src_if.sv
source/irq_sync.sv
source/mtimer.sv
source/irq_prio_arbiter.sv
source/irq_path_top.sv
test/tb_clkgen.sv
test/irq_path_chk.sv
test/irq_scoreboard.sv
test/irq_path_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the interrupt path testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f irq_path.f --top-module irq_path_tb \
  -o sim_irq_path > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_irq_path +verilator+error+limit+1000000 > sim.log 2>&1 || echo "simulator exit status nonzero"
cat sim.log

if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
  exit 1
fi
exit 0

/* test/irq_path_tb.sv */
/*
 * testbench top for the interrupt delivery path
 * random episodes of source levels, timer writes and acknowledges
 */
module irq_path_tb
  import irq_map_pkg::*;
  import mtimer_pkg::*;
;

  localparam int n_episodes     = 400;
  localparam int episode_cycles = 20;
  localparam int margin_cycles  = 200;

  logic        clk;
  logic        rst_n;
  logic        rtc;
  logic        meip;
  logic        seip;
  logic        msip;
  logic [15:0] plat_irq;
  logic        cmp_we;
  mtime_t      cmp_val;
  logic [31:0] enable;
  logic        ack;
  logic        req;
  irq_id_t     id;
  logic [31:0] onehot;
  mtime_t      mtime;
  int          id_err;
  int          mask_err;
  int          onehot_err;
  int          hs_err;
  int          mtime_err;
  integer      seed;

  tb_clkgen u_clkgen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  irq_path_top dut_i (
    .clk_i         ( clk      ),
    .ndmreset_n    ( rst_n    ),
    .rtc_i         ( rtc      ),
    .meip_i        ( meip     ),
    .seip_i        ( seip     ),
    .msip_i        ( msip     ),
    .plat_irq_i    ( plat_irq ),
    .mtimecmp_we_i ( cmp_we   ),
    .mtimecmp_i    ( cmp_val  ),
    .irq_enable_i  ( enable   ),
    .irq_ack_i     ( ack      ),
    .irq_req_o     ( req      ),
    .irq_id_o      ( id       ),
    .irq_onehot_o  ( onehot   ),
    .mtime_o       ( mtime    )
  );

  irq_scoreboard u_scoreboard (
    .clk_i (clk), .ndmreset_n (rst_n), .rtc_i (rtc), .meip_i (meip),
    .seip_i (seip), .msip_i (msip), .plat_irq_i (plat_irq),
    .mtimecmp_we_i (cmp_we), .mtimecmp_i (cmp_val), .irq_enable_i (enable),
    .irq_ack_i (ack), .irq_req_i (req), .irq_id_i (id), .irq_onehot_i (onehot),
    .mtime_i (mtime), .id_err_o (id_err), .mask_err_o (mask_err),
    .onehot_err_o (onehot_err), .hs_err_o (hs_err), .mtime_err_o (mtime_err)
  );

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // compare write takes one cycle of its own
  task automatic write_compare();
    logic [31:0] rnd;
    rnd = $random(seed);
    cmp_we  = 1'b1;
    cmp_val = mtime_t'(rnd[7:0]);
    next_cycle();
    cmp_we = 1'b0;
  endtask

  task automatic apply_levels();
    logic [31:0] rnd;
    rnd = $random(seed);
    {rtc, meip, seip, msip} = rnd[3:0];
    // platform lines quiet now and then, so the low ids get a turn
    plat_irq = (rnd[5:4] == 2'd0) ? '0 : rnd[31:16];
    rnd = $random(seed);
    // an empty mask now and then
    enable = (rnd[2:0] == 3'd0) ? '0 : rnd;
  endtask

  task automatic ack_if_requested();
    logic [31:0] rnd;
    rnd = $random(seed);
    repeat (rnd % 6) next_cycle();
    if (req) begin
      ack = 1'b1;
      next_cycle();
      ack = 1'b0;
    end
  endtask

  initial begin
    seed     = 32'h5d03cb0b;
    rtc      = 1'b0;
    meip     = 1'b0;
    seip     = 1'b0;
    msip     = 1'b0;
    plat_irq = '0;
    cmp_we   = 1'b0;
    cmp_val  = '0;
    enable   = '0;
    ack      = 1'b0;
    wait (rst_n);
    next_cycle();
    for (int ep = 0; ep < n_episodes; ep++) begin
      if (($random(seed) & 3) == 0) begin
        write_compare();
      end
      apply_levels();
      repeat (8) next_cycle();
      ack_if_requested();
      repeat (4) next_cycle();
    end
    repeat (10) next_cycle();
    $display("errors: id %0d mask %0d onehot %0d handshake %0d mtime %0d",
             id_err, mask_err, onehot_err, hs_err, mtime_err);
    if (id_err + mask_err + onehot_err + hs_err + mtime_err == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((n_episodes * episode_cycles + margin_cycles + 10) * 10);
    $display("run timed out before all episodes finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

/* test/irq_scoreboard.sv */
/*
 * reference model of the interrupt path
 * compares priority, masking, one-hot word, handshake and mtime
 */
`include "irq_path_defs.svh"

module irq_scoreboard
  import irq_map_pkg::*;
  import mtimer_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    rtc_i,
  input  logic                    meip_i,
  input  logic                    seip_i,
  input  logic                    msip_i,
  input  logic [`PLAT_IRQ_W-1:0]  plat_irq_i,
  input  logic                    mtimecmp_we_i,
  input  mtime_t                  mtimecmp_i,
  input  logic [`IRQ_NUM_SRC-1:0] irq_enable_i,
  input  logic                    irq_ack_i,
  input  logic                    irq_req_i,
  input  irq_id_t                 irq_id_i,
  input  logic [`IRQ_NUM_SRC-1:0] irq_onehot_i,
  input  mtime_t                  mtime_i,
  output int                      id_err_o,
  output int                      mask_err_o,
  output int                      onehot_err_o,
  output int                      hs_err_o,
  output int                      mtime_err_o
);

  // worst path is rtc -> mtime -> mtip -> pending -> request
  localparam int settle_req   = 7;
  localparam int settle_mtime = 6;

  logic [`PLAT_IRQ_W+4+1+`MTIME_W+`IRQ_NUM_SRC-1:0] in_now;
  logic [`PLAT_IRQ_W+4+1+`MTIME_W+`IRQ_NUM_SRC-1:0] in_prev;
  int                      stable_cnt;
  logic                    rtc_prev;
  mtime_t                  edges;
  mtime_t                  cmp_model;
  logic                    req_prev;
  logic                    ack_prev;
  irq_id_t                 id_prev;
  logic [`IRQ_NUM_SRC-1:0] pend_model;
  logic [`IRQ_NUM_SRC-1:0] masked_model;
  logic [`IRQ_NUM_SRC-1:0] onehot_exp;
  int                      exp_id;

  // highest set bit, -1 when empty
  function automatic int top_bit(input logic [`IRQ_NUM_SRC-1:0] w);
    int r;
    r = -1;
    for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
      if (w[i]) begin
        r = i;
      end
    end
    return r;
  endfunction

  assign in_now = {rtc_i, meip_i, seip_i, msip_i, plat_irq_i, mtimecmp_we_i,
                   mtimecmp_i, irq_enable_i};

  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      in_prev      = 'x;
      stable_cnt   = 0;
      rtc_prev     = 1'b0;
      edges        = '0;
      cmp_model    = '1;
      req_prev     = 1'b0;
      ack_prev     = 1'b0;
      id_prev      = '0;
      id_err_o     = 0;
      mask_err_o   = 0;
      onehot_err_o = 0;
      hs_err_o     = 0;
      mtime_err_o  = 0;
    end else begin
      // stable window bookkeeping
      if (in_now !== in_prev) begin
        stable_cnt = 0;
      end else if (stable_cnt < 1000) begin
        stable_cnt = stable_cnt + 1;
      end
      in_prev = in_now;
      if (rtc_i && !rtc_prev) begin
        edges = edges + mtime_t'(1);
      end
      rtc_prev = rtc_i;
      if (mtimecmp_we_i) begin
        cmp_model = mtimecmp_i;
      end

      pend_model = '0;
      pend_model[`IRQ_NUM_SRC-1:`IRQ_NUM_SRC-`PLAT_IRQ_W] = plat_irq_i;
      pend_model[`IRQ_MEIP_BIT] = meip_i;
      pend_model[`IRQ_SEIP_BIT] = seip_i;
      pend_model[`IRQ_MSIP_BIT] = msip_i;
      pend_model[`IRQ_MTIP_BIT] = (cmp_model <= edges);
      masked_model = pend_model & irq_enable_i;
      exp_id = top_bit(masked_model);

      // -------------------
      // one-hot word
      // -------------------
      onehot_exp = '0;
      if (irq_req_i) begin
        onehot_exp = 32'h1 << irq_id_i;
      end
      if (irq_onehot_i !== onehot_exp) begin
        $display("** Error: irq_onehot_o got %h expected %h", irq_onehot_i, onehot_exp);
        onehot_err_o = onehot_err_o + 1;
      end

      // handshake, mirrors the bound assertions
      if (req_prev && !ack_prev && (!irq_req_i || irq_id_i !== id_prev)) begin
        $display("request or id changed before the acknowledge");
        hs_err_o = hs_err_o + 1;
      end
      if (req_prev && ack_prev && irq_req_i) begin
        $display("request stayed high in the cycle after the acknowledge");
        hs_err_o = hs_err_o + 1;
      end

      // -------------------
      // priority and masking
      // -------------------
      if (stable_cnt >= settle_req && irq_req_i && !req_prev) begin
        if (exp_id < 0) begin
          $display("request raised with nothing enabled and pending");
          mask_err_o = mask_err_o + 1;
        end else if (irq_id_i !== irq_id_t'(exp_id)) begin
          $display("** Error: irq_id_o got %h expected %h", irq_id_i, irq_id_t'(exp_id));
          id_err_o = id_err_o + 1;
        end
      end

      // the idle cycle right after an acknowledge is allowed
      if (stable_cnt >= settle_req && exp_id >= 0 && !irq_req_i &&
          !(req_prev && ack_prev)) begin
        $display("no request raised although an enabled source is pending");
        mask_err_o = mask_err_o + 1;
      end

      if (stable_cnt >= settle_mtime && mtime_i !== edges) begin
        $display("** Error: mtime_o got %h expected %h", mtime_i, edges);
        mtime_err_o = mtime_err_o + 1;
      end

      req_prev = irq_req_i;
      ack_prev = irq_ack_i;
      id_prev  = irq_id_i;
    end
  end

endmodule

/* test/irq_path_chk.sv */
/*
 * request handshake assertions for the priority stage
 */
module irq_path_chk
  import irq_map_pkg::*;
(
  input logic        clk_i,
  input logic        ndmreset_n,
  input logic        req_i,
  input logic        ack_i,
  input irq_id_t     id_i,
  input logic [31:0] onehot_i
);

  // request and id hold until the core takes them
  req_hold_a: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (req_i && !ack_i) |=> (req_i && $stable(id_i)))
    else $error("request or id moved while not acknowledged");

  // one idle cycle after an acknowledge
  req_drop_a: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (req_i && ack_i) |=> !req_i)
    else $error("request still high after acknowledge");

  onehot_idle_a: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !req_i |-> (onehot_i == '0))
    else $error("one-hot word not zero without a request");

endmodule

bind irq_prio_arbiter irq_path_chk u_irq_path_chk (
  .clk_i      ( clk_i        ),
  .ndmreset_n ( ndmreset_n   ),
  .req_i      ( irq_req_o    ),
  .ack_i      ( irq_ack_i    ),
  .id_i       ( irq_id_o     ),
  .onehot_i   ( irq_onehot_o )
);

/* test/tb_clkgen.sv */
/*
 * testbench clock and reset source
 * period of 10, reset held low for 10 cycles
 */
module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release just after an edge, away from sampling
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

/* source/irq_path_top.sv */
/*
 * interrupt delivery path in front of the core
 * synchronize, machine timer, then priority selection
 */
`include "irq_path_defs.svh"

module irq_path_top
  import irq_map_pkg::*;
  import mtimer_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    rtc_i,
  input  logic                    meip_i,
  input  logic                    seip_i,
  input  logic                    msip_i,
  input  logic [`PLAT_IRQ_W-1:0]  plat_irq_i,
  input  logic                    mtimecmp_we_i,
  input  mtime_t                  mtimecmp_i,
  input  logic [`IRQ_NUM_SRC-1:0] irq_enable_i,
  input  logic                    irq_ack_i,
  output logic                    irq_req_o,
  output irq_id_t                 irq_id_o,
  output logic [`IRQ_NUM_SRC-1:0] irq_onehot_o,
  output mtime_t                  mtime_o
);

  // sources between the stages
  irq_src_if src_if ();

  // --------------------
  // synchronizer
  // --------------------
  irq_sync i_irq_sync (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .rtc_i      ( rtc_i      ),
    .meip_i     ( meip_i     ),
    .seip_i     ( seip_i     ),
    .msip_i     ( msip_i     ),
    .plat_irq_i ( plat_irq_i ),
    .src        ( src_if     )
  );

  // --------------------
  // machine timer
  // --------------------
  mtimer i_mtimer (
    .clk_i         ( clk_i         ),
    .ndmreset_n    ( ndmreset_n    ),
    .mtimecmp_we_i ( mtimecmp_we_i ),
    .mtimecmp_i    ( mtimecmp_i    ),
    .mtime_o       ( mtime_o       ),
    .src           ( src_if        )
  );

  // priority and core handshake
  irq_prio_arbiter i_irq_prio_arbiter (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .irq_enable_i ( irq_enable_i ),
    .irq_ack_i    ( irq_ack_i    ),
    .irq_req_o    ( irq_req_o    ),
    .irq_id_o     ( irq_id_o     ),
    .irq_onehot_o ( irq_onehot_o ),
    .src          ( src_if       )
  );

endmodule

/* source/irq_prio_arbiter.sv */
/*
 * priority stage
 * latches the pending word, picks the highest enabled id and
 * holds the request towards the core until it is acknowledged
 */
`include "irq_path_defs.svh"

module irq_prio_arbiter
  import irq_map_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic [`IRQ_NUM_SRC-1:0] irq_enable_i,
  input  logic                    irq_ack_i,
  output logic                    irq_req_o,
  output irq_id_t                 irq_id_o,
  output logic [`IRQ_NUM_SRC-1:0] irq_onehot_o,
  irq_src_if.prio                 src
);

  irq_word_u               pend_d;
  irq_word_u               pend_q;
  logic [`IRQ_NUM_SRC-1:0] masked;
  logic                    any_pend;
  irq_id_t                 sel_id;
  logic                    req_q;
  irq_id_t                 id_q;

  // --------------------
  // pending word
  // --------------------
  always_comb begin
    pend_d                    = '0;
    pend_d.fields.plat        = src.plat;
    pend_d.fields.std.meip    = src.meip;
    pend_d.fields.std.seip    = src.seip;
    pend_d.fields.std.mtip    = src.mtip;
    pend_d.fields.std.msip    = src.msip;
  end

  // keeps updating while a request is outstanding
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  // --------------------
  // selection
  // --------------------
  assign masked   = pend_q.flat & irq_enable_i;
  assign any_pend = |masked;

  // higher id wins, so the last hit in the loop is kept
  always_comb begin
    sel_id = '0;
    for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
      if (masked[i]) begin
        sel_id = irq_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      req_q <= 1'b0;
    end else if (req_q) begin
      if (irq_ack_i) begin
        req_q <= 1'b0;
      end
    end else if (any_pend) begin
      req_q <= 1'b1;
    end
  end

  // id only moves when a new request is raised
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      id_q <= '0;
    end else if (!req_q && any_pend) begin
      id_q <= sel_id;
    end
  end

  // one-hot word towards the core
  always_comb begin
    irq_onehot_o = '0;
    if (req_q) begin
      irq_onehot_o[id_q] = 1'b1;
    end
  end

  assign irq_req_o = req_q;
  assign irq_id_o  = id_q;

endmodule

/* source/mtimer.sv */
/*
 * machine timer stage
 * mtime counts rtc ticks, mtip is raised once mtime reaches mtimecmp
 */
`include "irq_path_defs.svh"

module mtimer
  import mtimer_pkg::*;
(
  input  logic    clk_i,
  input  logic    ndmreset_n,
  input  logic    mtimecmp_we_i,
  input  mtime_t  mtimecmp_i,
  output mtime_t  mtime_o,
  irq_src_if.timer src
);

  mtime_t mtime_q;
  mtime_t mtimecmp_q;
  logic   mtip_q;

  // --------------------
  // time counter
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q <= '0;
    end else if (src.rtc_tick) begin
      mtime_q <= mtime_q + mtime_step;
    end
  end

  // compare register, written by the core side
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtimecmp_q <= mtimecmp_rst_val;
    end else if (mtimecmp_we_i) begin
      mtimecmp_q <= mtimecmp_i;
    end
  end

  // --------------------
  // timer interrupt
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtip_q <= 1'b0;
    end else begin
      mtip_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign src.mtip = mtip_q;
  assign mtime_o  = mtime_q;

endmodule

/* source/irq_sync.sv */
/*
 * input synchronizer stage
 * brings the asynchronous interrupt lines into clk_i and makes the rtc tick
 */
`include "irq_path_defs.svh"

module irq_sync (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   rtc_i,
  input  logic                   meip_i,
  input  logic                   seip_i,
  input  logic                   msip_i,
  input  logic [`PLAT_IRQ_W-1:0] plat_irq_i,
  irq_src_if.sync                src
);

  // platform lines, msip, seip, meip and rtc
  localparam int unsigned n_lines = `PLAT_IRQ_W + 4;

  logic [n_lines-1:0]                    async_in;
  logic [`SYNC_STAGES-1:0][n_lines-1:0]  sync_q;
  logic [n_lines-1:0]                    sync_out;
  logic                                  rtc_s;
  logic                                  rtc_q;
  logic                                  tick_q;

  assign async_in = {rtc_i, meip_i, seip_i, msip_i, plat_irq_i};

  // --------------------
  // flop chain
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`SYNC_STAGES-2:0], async_in};
    end
  end

  assign sync_out = sync_q[`SYNC_STAGES-1];
  assign rtc_s    = sync_out[`PLAT_IRQ_W+3];

  // --------------------
  // rtc edge detect
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q  <= 1'b0;
      tick_q <= 1'b0;
    end else begin
      rtc_q  <= rtc_s;
      // one pulse per rising edge
      tick_q <= rtc_s & ~rtc_q;
    end
  end

  assign src.rtc_tick = tick_q;
  assign src.meip     = sync_out[`PLAT_IRQ_W+2];
  assign src.seip     = sync_out[`PLAT_IRQ_W+1];
  assign src.msip     = sync_out[`PLAT_IRQ_W];
  assign src.plat     = sync_out[`PLAT_IRQ_W-1:0];

endmodule

/* source/irq_src_if.sv */
/*
 * interrupt source bundle between the pipeline stages
 * synchronized lines, rtc tick and timer interrupt
 */
`include "irq_path_defs.svh"

interface irq_src_if;

  logic                   rtc_tick;
  logic                   meip;
  logic                   seip;
  logic                   msip;
  logic [`PLAT_IRQ_W-1:0] plat;
  logic                   mtip;

  modport sync (output rtc_tick, meip, seip, msip, plat);

  modport timer (input rtc_tick, output mtip);

  modport prio (input meip, seip, msip, plat, mtip);

endinterface

/* source/mtimer_pkg.sv */
/*
 * machine timer types
 * one count type serves both mtime and mtimecmp
 */
`include "irq_path_defs.svh"

package mtimer_pkg;

  typedef logic [`MTIME_W-1:0] mtime_t;

  // compare value after reset, keeps mtip low
  localparam mtime_t mtimecmp_rst_val = '1;

  // increment step per real-time clock tick
  localparam mtime_t mtime_step = mtime_t'(1);

endpackage

/* source/irq_map_pkg.sv */
/*
 * local interrupt numbering
 * source id type and the two views of the pending word
 */
`include "irq_path_defs.svh"

package irq_map_pkg;

  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

  // standard local interrupt layout, ids 15 down to 0
  typedef struct packed {
    logic [3:0] rsvd_15_12;
    logic       meip;
    logic       rsvd_10;
    logic       seip;
    logic       rsvd_8;
    logic       mtip;
    logic [2:0] rsvd_6_4;
    logic       msip;
    logic [2:0] rsvd_2_0;
  } irq_std_t;

  typedef struct packed {
    logic [`PLAT_IRQ_W-1:0] plat;
    irq_std_t               std;
  } irq_fields_t;

  // flat view for masking and search, field view for filling
  typedef union packed {
    logic [`IRQ_NUM_SRC-1:0] flat;
    irq_fields_t             fields;
  } irq_word_u;

endpackage

/* source/irq_path_defs.svh */
/*
 * interrupt path widths and counts
 * source count, id width, timer width and standard bit positions
 */
`ifndef IRQ_PATH_DEFS_SVH
`define IRQ_PATH_DEFS_SVH

`define IRQ_NUM_SRC   32
`define IRQ_ID_W      5
`define MTIME_W       64
`define SYNC_STAGES   2
`define PLAT_IRQ_W    16

`define IRQ_MSIP_BIT  3
`define IRQ_MTIP_BIT  7
`define IRQ_SEIP_BIT  9
`define IRQ_MEIP_BIT  11

`endif
